/* riscvCpu_stimulus.mem */
// tag address value (hex): P program word, D initial data, W expected store in order
// E expected final data word
P 00000000 00500093
P 00000004 FFD00113
P 00000008 002081B3
P 0000000C 40208233
P 00000010 0020F2B3
P 00000014 00112333
P 00000018 001093B3
P 0000001C 00115433
P 00000020 401154B3
P 00000024 20302023
P 00000028 20402223
P 0000002C 20502423
P 00000030 20602623
P 00000034 20702823
P 00000038 20802A23
P 0000003C 20902C23
P 00000040 10002503
P 00000044 10402583
P 00000048 00B50633
P 0000004C 00700013
P 00000050 20C02E23
P 00000054 22002023
P 00000058 00108463
P 0000005C 24102023
P 00000060 00208463
P 00000064 22302223
P 00000068 00114463
P 0000006C 24102223
P 00000070 0020C463
P 00000074 22402423
P 00000078 0080076F
P 0000007C 24102423
P 00000080 088007E7
P 00000084 24102623
P 00000088 22E02623
P 0000008C 22F02823
P 00000090 ABCDE837
P 00000094 00001897
P 00000098 23002A23
P 0000009C 23102C23
P 000000A0 0000006F
D 00000100 00001234
D 00000104 00000010
W 00000200 00000002
W 00000204 00000008
W 00000208 00000005
W 0000020C 00000001
W 00000210 000000A0
W 00000214 07FFFFFF
W 00000218 FFFFFFFF
W 0000021C 00001244
W 00000220 00000000
W 00000224 00000002
W 00000228 00000008
W 0000022C 0000007C
W 00000230 00000084
W 00000234 ABCDE000
W 00000238 00001094
E 00000224 00000002
E 00000228 00000008
E 00000240 00000000
E 00000244 00000000
E 00000248 00000000
E 0000024C 00000000

/* riscvCpu.f */
+incdir+.
rv32IsaPkg.sv
cpuCtrlPkg.sv
controlDecoder.sv
immediateGen.sv
registerFile.sv
alu.sv
riscvCpu.sv
tb_riscvCpu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f riscvCpu.f --top-module tb_riscvCpu -o simv

output=$(./obj_dir/simv) || true
echo "$output"

if echo "$output" | grep -q "Testbench passed"; then
    exit 0
else
    exit 1
fi

/* tb_riscvCpu.sv */
`timescale 1ns/1ps
`include "riscvCpu_config.svh"

module tb_riscvCpu;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] instruction;
    logic             writeEnable;
    logic [`XLEN-1:0] dataAddress;
    logic [`XLEN-1:0] writeData;
    logic [`XLEN-1:0] readData;

    // word-addressed 1 KiB memories
    logic [`XLEN-1:0] instrMem [0:255];
    logic [`XLEN-1:0] dataMem  [0:255];

    logic [`XLEN-1:0] storeAddrQ [$];
    logic [`XLEN-1:0] storeDataQ [$];
    logic [`XLEN-1:0] finalAddrQ [$];
    logic [`XLEN-1:0] finalDataQ [$];

    int errors;
    int checks;

    riscvCpu uut (
        .clk         (clk),
        .reset       (reset),
        .pc          (pc),
        .instruction (instruction),
        .writeEnable (writeEnable),
        .dataAddress (dataAddress),
        .writeData   (writeData),
        .readData    (readData)
    );

    assign instruction = instrMem[pc[9:2]];
    assign readData    = dataMem[dataAddress[9:2]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [`XLEN-1:0] expected,
                              input logic [`XLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // stores commit at the edge that ends the cycle
    always @(posedge clk) begin
        if (writeEnable && !reset) begin
            if (storeAddrQ.size() == 0) begin
                errors++;
                $display("unexpected store of %h to address %h", writeData, dataAddress);
            end else begin
                checkValue("store address", storeAddrQ.pop_front(), dataAddress);
                checkValue("store data", storeDataQ.pop_front(), writeData);
            end
            dataMem[dataAddress[9:2]] <= writeData;
        end
    end

    task automatic loadStimulus();
        int fd;
        int code;
        byte tag;
        string rest;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] value;
        fd = $fopen("riscvCpu_stimulus.mem", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "/") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h", addr, value);
                case (tag)
                    "P": instrMem[addr[9:2]] = value;
                    "D": dataMem[addr[9:2]] = value;
                    "W": begin
                        storeAddrQ.push_back(addr);
                        storeDataQ.push_back(value);
                    end
                    "E": begin
                        finalAddrQ.push_back(addr);
                        finalDataQ.push_back(value);
                    end
                    default: begin
                        errors++;
                        $display("unknown record tag in the stimulus file");
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    initial begin
        logic [`XLEN-1:0] prevPc;
        int stable;
        int cycles;
        errors = 0;
        checks = 0;
        reset  = 1'b1;
        for (int idx = 0; idx < 256; idx++) begin
            instrMem[idx] = '0;
            dataMem[idx]  = '0;
        end
        loadStimulus();

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // pc holds its reset value until the first edge with reset low
        @(negedge clk);
        checkValue("reset pc", `PC_RESET, pc);
        checkValue("first fetch", instrMem[0], instruction);

        // the program parks on a jal to itself
        prevPc = pc;
        stable = 0;
        cycles = 0;
        while (stable < 2 && cycles < 2000) begin
            @(negedge clk);
            if (pc == prevPc) begin
                stable++;
            end else begin
                stable = 0;
            end
            prevPc = pc;
            cycles++;
        end
        if (stable < 2) begin
            errors++;
            $display("program did not reach its final loop within 2000 cycles");
        end
        if (storeAddrQ.size() != 0) begin
            errors++;
            $display("%0d expected stores never happened", storeAddrQ.size());
        end
        while (finalAddrQ.size() != 0) begin
            prevPc = finalAddrQ.pop_front();
            checkValue("final memory", finalDataQ.pop_front(), dataMem[prevPc[9:2]]);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* riscvCpu.sv */
`timescale 1ns/1ps
`include "riscvCpu_config.svh"

module riscvCpu (
    input  logic             clk,
    input  logic             reset,
    output logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] instruction,
    output logic             writeEnable,
    output logic [`XLEN-1:0] dataAddress,
    output logic [`XLEN-1:0] writeData,
    input  logic [`XLEN-1:0] readData
);

    rv32IsaPkg::instrWord_t instr;

    logic             regWrite;
    logic             memWrite;
    logic             memToReg;
    logic             aluSrcImm;
    logic             branchEq;
    logic             branchLt;
    logic             jump;
    logic             jumpReg;
    logic             loadUpper;
    logic             addUpperPc;
    logic [3:0]       aluOp;
    logic [2:0]       immSel;

    logic [`XLEN-1:0] pcReg;
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcPlusImm;
    logic [`XLEN-1:0] immediate;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] aluSrcB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] regWriteData;
    logic             aluZero;
    logic             aluLessThan;
    logic             branchTaken;

    assign instr = instruction;

    controlDecoder ctrl (
        .instruction (instr),
        .regWrite    (regWrite),
        .memWrite    (memWrite),
        .memToReg    (memToReg),
        .aluSrcImm   (aluSrcImm),
        .branchEq    (branchEq),
        .branchLt    (branchLt),
        .jump        (jump),
        .jumpReg     (jumpReg),
        .loadUpper   (loadUpper),
        .addUpperPc  (addUpperPc),
        .aluOp       (aluOp),
        .immSel      (immSel)
    );

    immediateGen immGen (
        .instruction (instr),
        .immSel      (immSel),
        .immediate   (immediate)
    );

    registerFile regFile (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (regWrite),
        .readAddrA   (instr.r.rs1),
        .readAddrB   (instr.r.rs2),
        .writeAddr   (instr.r.rd),
        .writeData   (regWriteData),
        .readDataA   (rs1Data),
        .readDataB   (rs2Data)
    );

    assign aluSrcB = aluSrcImm ? immediate : rs2Data;

    alu aluUnit (
        .aluOp    (aluOp),
        .srcA     (rs1Data),
        .srcB     (aluSrcB),
        .result   (aluResult),
        .zero     (aluZero),
        .lessThan (aluLessThan)
    );

    assign pcPlus4   = pcReg + `XLEN'(4);
    assign pcPlusImm = pcReg + immediate;

    assign branchTaken = jump | (branchEq & aluZero) | (branchLt & aluLessThan);

    always_comb begin
        if (jumpReg) begin
            nextPc = aluResult;
        end else if (branchTaken) begin
            nextPc = pcPlusImm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pcReg <= `PC_RESET;
        end else begin
            pcReg <= nextPc;
        end
    end

    // write-back select, upper-immediate ops first
    always_comb begin
        if (loadUpper) begin
            regWriteData = immediate;
        end else if (addUpperPc) begin
            regWriteData = pcPlusImm;
        end else if (memToReg) begin
            regWriteData = readData;
        end else if (jump || jumpReg) begin
            regWriteData = pcPlus4;
        end else begin
            regWriteData = aluResult;
        end
    end

    assign pc          = pcReg;
    assign writeEnable = memWrite;
    assign dataAddress = aluResult;
    assign writeData   = rs2Data;

endmodule

/* alu.sv */
`timescale 1ns/1ps
`include "riscvCpu_config.svh"

module alu (
    input  logic [3:0]       aluOp,
    input  logic [`XLEN-1:0] srcA,
    input  logic [`XLEN-1:0] srcB,
    output logic [`XLEN-1:0] result,
    output logic             zero,
    output logic             lessThan
);

    logic [4:0] shiftAmount;

    // shifts honour only the low five bits
    assign shiftAmount = srcB[4:0];

    // flag is valid for every op so blt can use it directly
    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluOp)
            cpuCtrlPkg::ALU_ADD: begin
                result = srcA + srcB;
            end
            cpuCtrlPkg::ALU_SUB: begin
                result = srcA - srcB;
            end
            cpuCtrlPkg::ALU_AND: begin
                result = srcA & srcB;
            end
            cpuCtrlPkg::ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, lessThan};
            end
            cpuCtrlPkg::ALU_SLL: begin
                result = srcA << shiftAmount;
            end
            cpuCtrlPkg::ALU_SRL: begin
                result = srcA >> shiftAmount;
            end
            cpuCtrlPkg::ALU_SRA: begin
                result = $unsigned($signed(srcA) >>> shiftAmount);
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

/* registerFile.sv */
`timescale 1ns/1ps
`include "riscvCpu_config.svh"

module registerFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   writeEnable,
    input  logic [`REG_ADDR_W-1:0] readAddrA,
    input  logic [`REG_ADDR_W-1:0] readAddrB,
    input  logic [`REG_ADDR_W-1:0] writeAddr,
    input  logic [`XLEN-1:0]       writeData,
    output logic [`XLEN-1:0]       readDataA,
    output logic [`XLEN-1:0]       readDataB
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int idx = 0; idx < `REG_COUNT; idx++) begin
                regs[idx] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // x0 is hardwired
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

/* immediateGen.sv */
`timescale 1ns/1ps
`include "riscvCpu_config.svh"

module immediateGen (
    input  rv32IsaPkg::instrWord_t instruction,
    input  logic [2:0]             immSel,
    output logic [`XLEN-1:0]       immediate
);

    always_comb begin
        case (immSel)
            cpuCtrlPkg::IMM_I: begin
                immediate = {{20{instruction.i.imm11to0[11]}}, instruction.i.imm11to0};
            end
            cpuCtrlPkg::IMM_S: begin
                immediate = {{20{instruction.s.imm11to5[6]}},
                             instruction.s.imm11to5, instruction.s.imm4to0};
            end
            cpuCtrlPkg::IMM_B: begin
                immediate = {{20{instruction.b.imm12}}, instruction.b.imm11,
                             instruction.b.imm10to5, instruction.b.imm4to1, 1'b0};
            end
            cpuCtrlPkg::IMM_U: begin
                immediate = {instruction.u.imm31to12, 12'b0};
            end
            cpuCtrlPkg::IMM_J: begin
                // bit 0 is always zero for jump offsets
                immediate = {{12{instruction.j.imm20}}, instruction.j.imm19to12,
                             instruction.j.imm11, instruction.j.imm10to1, 1'b0};
            end
            default: begin
                immediate = '0;
            end
        endcase
    end

endmodule

/* controlDecoder.sv */
`timescale 1ns/1ps

module controlDecoder (
    input  rv32IsaPkg::instrWord_t instruction,
    output logic                   regWrite,
    output logic                   memWrite,
    output logic                   memToReg,
    output logic                   aluSrcImm,
    output logic                   branchEq,
    output logic                   branchLt,
    output logic                   jump,
    output logic                   jumpReg,
    output logic                   loadUpper,
    output logic                   addUpperPc,
    output logic [3:0]             aluOp,
    output logic [2:0]             immSel
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = instruction.r.funct3;
    assign funct7 = instruction.r.funct7;

    always_comb begin
        regWrite   = 1'b0;
        memWrite   = 1'b0;
        memToReg   = 1'b0;
        aluSrcImm  = 1'b0;
        branchEq   = 1'b0;
        branchLt   = 1'b0;
        jump       = 1'b0;
        jumpReg    = 1'b0;
        loadUpper  = 1'b0;
        addUpperPc = 1'b0;
        aluOp      = cpuCtrlPkg::ALU_ADD;
        immSel     = cpuCtrlPkg::IMM_I;

        case (instruction.r.opcode)
            rv32IsaPkg::OP_REG: begin
                // only the listed funct3/funct7 pairs write back
                regWrite = 1'b1;
                if (funct3 == rv32IsaPkg::FUNCT3_ADD_SUB && funct7 == rv32IsaPkg::FUNCT7_BASE) begin
                    aluOp = cpuCtrlPkg::ALU_ADD;
                end else if (funct3 == rv32IsaPkg::FUNCT3_ADD_SUB
                             && funct7 == rv32IsaPkg::FUNCT7_ALT) begin
                    aluOp = cpuCtrlPkg::ALU_SUB;
                end else if (funct3 == rv32IsaPkg::FUNCT3_AND && funct7 == rv32IsaPkg::FUNCT7_BASE) begin
                    aluOp = cpuCtrlPkg::ALU_AND;
                end else if (funct3 == rv32IsaPkg::FUNCT3_SLT && funct7 == rv32IsaPkg::FUNCT7_BASE) begin
                    aluOp = cpuCtrlPkg::ALU_SLT;
                end else if (funct3 == rv32IsaPkg::FUNCT3_SLL && funct7 == rv32IsaPkg::FUNCT7_BASE) begin
                    aluOp = cpuCtrlPkg::ALU_SLL;
                end else if (funct3 == rv32IsaPkg::FUNCT3_SRL_SRA
                             && funct7 == rv32IsaPkg::FUNCT7_BASE) begin
                    aluOp = cpuCtrlPkg::ALU_SRL;
                end else if (funct3 == rv32IsaPkg::FUNCT3_SRL_SRA
                             && funct7 == rv32IsaPkg::FUNCT7_ALT) begin
                    aluOp = cpuCtrlPkg::ALU_SRA;
                end else begin
                    regWrite = 1'b0;
                end
            end
            rv32IsaPkg::OP_IMM: begin
                // addi only
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            rv32IsaPkg::OP_LOAD: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                memToReg  = 1'b1;
            end
            rv32IsaPkg::OP_STORE: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                immSel    = cpuCtrlPkg::IMM_S;
            end
            rv32IsaPkg::OP_BRANCH: begin
                immSel = cpuCtrlPkg::IMM_B;
                if (funct3 == rv32IsaPkg::FUNCT3_BEQ) begin
                    branchEq = 1'b1;
                    aluOp    = cpuCtrlPkg::ALU_SUB;
                end else if (funct3 == rv32IsaPkg::FUNCT3_BLT) begin
                    branchLt = 1'b1;
                    aluOp    = cpuCtrlPkg::ALU_SLT;
                end
            end
            rv32IsaPkg::OP_LUI: begin
                regWrite  = 1'b1;
                loadUpper = 1'b1;
                immSel    = cpuCtrlPkg::IMM_U;
            end
            rv32IsaPkg::OP_AUIPC: begin
                regWrite   = 1'b1;
                addUpperPc = 1'b1;
                immSel     = cpuCtrlPkg::IMM_U;
            end
            rv32IsaPkg::OP_JAL: begin
                regWrite = 1'b1;
                jump     = 1'b1;
                immSel   = cpuCtrlPkg::IMM_J;
            end
            rv32IsaPkg::OP_JALR: begin
                // target comes from the alu sum rs1 + imm
                regWrite  = 1'b1;
                jumpReg   = 1'b1;
                aluSrcImm = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

/* cpuCtrlPkg.sv */
package cpuCtrlPkg;

    // alu operation select
    localparam logic [3:0] ALU_ADD = 4'd0;
    localparam logic [3:0] ALU_SUB = 4'd1;
    localparam logic [3:0] ALU_AND = 4'd2;
    localparam logic [3:0] ALU_SLT = 4'd3;
    localparam logic [3:0] ALU_SLL = 4'd4;
    localparam logic [3:0] ALU_SRL = 4'd5;
    localparam logic [3:0] ALU_SRA = 4'd6;

    // immediate format select
    localparam logic [2:0] IMM_I = 3'd0;
    localparam logic [2:0] IMM_S = 3'd1;
    localparam logic [2:0] IMM_B = 3'd2;
    localparam logic [2:0] IMM_U = 3'd3;
    localparam logic [2:0] IMM_J = 3'd4;

endpackage

/* rv32IsaPkg.sv */
package rv32IsaPkg;

    // one instruction word seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm11to0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm11to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4to0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm31to12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instrWord_t;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // register operations
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // branches
    localparam logic [2:0] FUNCT3_BEQ = 3'b000;
    localparam logic [2:0] FUNCT3_BLT = 3'b100;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage

/* riscvCpu_config.svh */
`ifndef RISCVCPU_CONFIG_SVH
`define RISCVCPU_CONFIG_SVH

// data, address and instruction width
`define XLEN 32

// general register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// first fetch address
`define PC_RESET 32'h0000_0000

`endif
